// File: hdu_pkg.sv
// widths and unit codes for the long-latency hazard unit; commit_id_w must cover log2 of the entry count
package hdu_pkg;

    // register file index, integer and fp files share the encoding
    localparam int reg_addr_w = 5;

    // scoreboard entry index handed out as commit id
    localparam int commit_id_w = 3;

    // execution unit type field
    localparam int exu_w = 2;

    // entries in the table unless the top level overrides it
    localparam int hdu_depth_default = 8;

    // long-latency unit that will write the destination
    typedef enum logic [exu_w-1:0] {
        exu_mul = 2'd0, // integer multiply
        exu_div = 2'd1, // integer divide / remainder
        exu_fpu = 2'd2  // floating point pipe
    } exu_type_t;
    // code 2'd3 left unused

endpackage

// File: hdu_slot_alloc.sv
// lowest free entry wins; grants nothing and reports id 0 while stalled or when no write is requested
`timescale 1ns/1ps

module hdu_slot_alloc #(
    parameter int DEPTH = hdu_pkg::hdu_depth_default
) (
    input  logic [DEPTH-1:0]                   valid_i,      // registered entry valid bits
    input  logic                               inst_valid_i, // request present
    input  logic                               rd_we_i,      // request writes a register
    input  logic                               stall_i,      // hazard or full table
    output logic [DEPTH-1:0]                   alloc_o,      // one-hot load strobe per entry
    output logic [hdu_pkg::commit_id_w-1:0]    commit_id_o   // index of the granted entry
);

    logic [DEPTH-1:0]                first_free; // one-hot, lowest clear valid bit
    logic [hdu_pkg::commit_id_w-1:0] free_idx;   // encoded form of first_free
    logic                            any_free;
    logic                            grant;

    // scan from the top down so the lowest free index is the last one kept
    always_comb begin
        first_free = '0;
        free_idx   = '0;
        any_free   = 1'b0;
        for (int k = DEPTH - 1; k >= 0; k--) begin
            if (!valid_i[k]) begin
                first_free    = '0;
                first_free[k] = 1'b1;
                free_idx      = k[hdu_pkg::commit_id_w-1:0];
                any_free      = 1'b1;
            end
        end
    end

    // only a hazard-free writing instruction takes an entry
    assign grant = inst_valid_i && rd_we_i && !stall_i && any_free;

    assign alloc_o     = grant ? first_free : '0;
    assign commit_id_o = grant ? free_idx : '0; // id 0 when nothing is granted

endmodule

// File: hdu_track_entry.sv
// one scoreboard slot; commits naming ENTRY_ID drop its hazards in the same cycle, ids must be below DEPTH
`timescale 1ns/1ps

module hdu_track_entry #(
    parameter int DEPTH    = hdu_pkg::hdu_depth_default,
    parameter int ENTRY_ID = 0
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            alloc_i,            // load this entry at the edge
    input  logic [hdu_pkg::reg_addr_w-1:0]  rd_addr_i,          // request destination
    input  hdu_pkg::exu_type_t              exu_type_i,         // request unit type
    input  logic [hdu_pkg::reg_addr_w-1:0]  rs1_addr_i,
    input  logic [hdu_pkg::reg_addr_w-1:0]  rs2_addr_i,
    input  logic [hdu_pkg::reg_addr_w-1:0]  rs3_addr_i,
    input  logic                            rs1_re_i,
    input  logic                            rs2_re_i,
    input  logic                            rs3_re_i,
    input  logic                            rd_we_i,
    input  logic                            inst_valid_i,
    input  logic                            commit_valid_int_i, // integer side retire strobe
    input  logic [hdu_pkg::commit_id_w-1:0] commit_id_int_i,
    input  logic                            commit_valid_fp_i,  // fp side retire strobe
    input  logic [hdu_pkg::commit_id_w-1:0] commit_id_fp_i,
    output logic                            valid_o,            // entry pending
    output logic                            raw_o,              // request reads our rd
    output logic                            waw_o               // request writes our rd, other unit
);

    localparam logic [hdu_pkg::commit_id_w-1:0] SELF_ID = ENTRY_ID[hdu_pkg::commit_id_w-1:0];

    logic                           valid_q;
    logic [hdu_pkg::reg_addr_w-1:0] rd_q;       // pending destination
    hdu_pkg::exu_type_t             exu_q;      // unit that owns the write
    logic                           commit_hit; // either port retires us now
    logic                           live;       // still able to cause a hazard
    logic                           src_hit;

    // index must fit both the table and the commit id field
    if (ENTRY_ID >= DEPTH || DEPTH > (1 << hdu_pkg::commit_id_w)) begin : g_cfg_err
        $error("hdu_track_entry: entry index %0d outside depth %0d", ENTRY_ID, DEPTH);
    end

    assign commit_hit = (commit_valid_int_i && commit_id_int_i == SELF_ID) ||
                        (commit_valid_fp_i  && commit_id_fp_i  == SELF_ID);

    assign live = valid_q && !commit_hit; // retiring this cycle counts as gone

    assign src_hit = (rs1_re_i && rs1_addr_i == rd_q) ||
                     (rs2_re_i && rs2_addr_i == rd_q) ||
                     (rs3_re_i && rs3_addr_i == rd_q);

    assign raw_o = inst_valid_i && live && src_hit;
    // same unit retires in order, so only a cross-unit write is a hazard
    assign waw_o = inst_valid_i && live && rd_we_i &&
                   (rd_addr_i == rd_q) && (exu_type_i != exu_q);

    // alloc and commit never hit the same entry, alloc needs it free
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (alloc_i) begin
            valid_q <= 1'b1;
        end else if (commit_hit) begin
            valid_q <= 1'b0; // freed at this edge
        end
    end

    // payload, qualified by valid_q
    always_ff @(posedge clk) begin
        if (alloc_i) begin
            rd_q  <= rd_addr_i;
            exu_q <= exu_type_i;
        end
    end

    assign valid_o = valid_q;

endmodule

// File: hdu_hazard_merge.sv
// stall covers raw, waw and a full table; the full check ignores same-cycle commits
`timescale 1ns/1ps

module hdu_hazard_merge #(
    parameter int DEPTH = hdu_pkg::hdu_depth_default
) (
    input  logic [DEPTH-1:0] valid_i,              // registered valid bits
    input  logic [DEPTH-1:0] raw_i,                // per-entry read-after-write
    input  logic [DEPTH-1:0] waw_i,                // per-entry write-after-write
    output logic             stall_o,              // back to the allocator
    output logic             hazard_stall_o,       // to the issue stage
    output logic             long_inst_atom_lock_o // something still in flight
);

    logic raw_any;
    logic waw_any;
    logic table_full;
    logic stall;

    assign raw_any = |raw_i;
    assign waw_any = |waw_i;

    // every slot taken, even if one retires this cycle it is not reusable yet
    assign table_full = &valid_i;

    assign stall = raw_any || waw_any || table_full;

    // same signal feeds both consumers
    assign stall_o        = stall;
    assign hazard_stall_o = stall;

    // registered bits only, so lock lags alloc and commit by one edge
    assign long_inst_atom_lock_o = |valid_i;

endmodule

// File: hdu_top.sv
// request is a level sampled each edge and must be held while stalled; commits must name pending entries
`timescale 1ns/1ps

module hdu_top #(
    parameter int DEPTH = hdu_pkg::hdu_depth_default // power of two, 2..8
) (
    input  logic                            clk,
    input  logic                            rst_n,
    // issue request
    input  logic                            inst_valid_i,
    input  logic                            rd_we_i,
    input  logic [hdu_pkg::reg_addr_w-1:0]  rd_addr_i,
    input  logic [hdu_pkg::reg_addr_w-1:0]  rs1_addr_i,
    input  logic [hdu_pkg::reg_addr_w-1:0]  rs2_addr_i,
    input  logic [hdu_pkg::reg_addr_w-1:0]  rs3_addr_i,
    input  logic                            rs1_re_i,
    input  logic                            rs2_re_i,
    input  logic                            rs3_re_i,     // fused multiply-add third source
    input  hdu_pkg::exu_type_t              exu_type_i,
    // retire ports
    input  logic                            commit_valid_int_i,
    input  logic [hdu_pkg::commit_id_w-1:0] commit_id_int_i,
    input  logic                            commit_valid_fp_i,
    input  logic [hdu_pkg::commit_id_w-1:0] commit_id_fp_i,
    // to the pipeline
    output logic                            hazard_stall_o,
    output logic [hdu_pkg::commit_id_w-1:0] commit_id_o,  // id travels with the instruction
    output logic                            long_inst_atom_lock_o
);

    logic [DEPTH-1:0] entry_valid; // registered valid per slot
    logic [DEPTH-1:0] entry_raw;
    logic [DEPTH-1:0] entry_waw;
    logic [DEPTH-1:0] alloc_grant; // one-hot load strobe
    logic             stall;       // merge -> allocator

    hdu_slot_alloc #(
        .DEPTH (DEPTH)
    ) u_alloc (
        .valid_i      (entry_valid),
        .inst_valid_i (inst_valid_i),
        .rd_we_i      (rd_we_i),
        .stall_i      (stall),
        .alloc_o      (alloc_grant),
        .commit_id_o  (commit_id_o)
    );

    // one slot per index, the index doubles as the commit id
    for (genvar g = 0; g < DEPTH; g++) begin : g_entry
        hdu_track_entry #(
            .DEPTH    (DEPTH),
            .ENTRY_ID (g)
        ) u_entry (
            .clk                (clk),
            .rst_n              (rst_n),
            .alloc_i            (alloc_grant[g]),
            .rd_addr_i          (rd_addr_i),
            .exu_type_i         (exu_type_i),
            .rs1_addr_i         (rs1_addr_i),
            .rs2_addr_i         (rs2_addr_i),
            .rs3_addr_i         (rs3_addr_i),
            .rs1_re_i           (rs1_re_i),
            .rs2_re_i           (rs2_re_i),
            .rs3_re_i           (rs3_re_i),
            .rd_we_i            (rd_we_i),
            .inst_valid_i       (inst_valid_i),
            .commit_valid_int_i (commit_valid_int_i),
            .commit_id_int_i    (commit_id_int_i),
            .commit_valid_fp_i  (commit_valid_fp_i),
            .commit_id_fp_i     (commit_id_fp_i),
            .valid_o            (entry_valid[g]),
            .raw_o              (entry_raw[g]),
            .waw_o              (entry_waw[g])
        );
    end

    hdu_hazard_merge #(
        .DEPTH (DEPTH)
    ) u_merge (
        .valid_i               (entry_valid),
        .raw_i                 (entry_raw),
        .waw_i                 (entry_waw),
        .stall_o               (stall),
        .hazard_stall_o        (hazard_stall_o),
        .long_inst_atom_lock_o (long_inst_atom_lock_o)
    );

endmodule

// File: tb_clock_gen.sv
// 20 ns clock from time 0; rst_n low until the third rising edge, released with an NBA
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 10, // ns
    parameter int RESET_CYCLES = 3
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    initial begin
        rst_n_o <= 1'b0;                        // async reset from time 0
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

// File: hdu_assert.sv
// bound into hdu_top; the id and x checks sleep while rst_n is low, failures are counted per property
`timescale 1ns/1ps

module hdu_assert (
    input logic                            clk,
    input logic                            rst_n,
    input logic                            stall_i,     // hazard_stall_o of the top
    input logic [hdu_pkg::commit_id_w-1:0] commit_id_i,
    input logic                            lock_i
);

    int lock_fail = 0;
    int id_fail   = 0;
    int x_fail    = 0;
    int fail_count;

    assign fail_count = lock_fail + id_fail + x_fail; // read by the testbench at the end

    // nothing can be allocated before the first edge out of reset
    a_lock_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !lock_i)
        else begin
            $error("lock went high in the cycle after reset");
            lock_fail++;
        end

    // a stalled request never gets an id
    a_id_zero_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
        stall_i |-> commit_id_i == '0)
        else begin
            $error("commit id not zero while stalled");
            id_fail++;
        end

    a_stall_known: assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(stall_i))
        else begin
            $error("hazard stall is unknown");
            x_fail++;
        end

endmodule

bind hdu_top hdu_assert u_hdu_assert (
    .clk         (clk),
    .rst_n       (rst_n),
    .stall_i     (hazard_stall_o),
    .commit_id_i (commit_id_o),
    .lock_i      (long_inst_atom_lock_o)
);

// File: hdu_tb.sv
// DEPTH 8 only; outputs checked at the falling edge against a scoreboard model, 2000 cycle limit
`timescale 1ns/1ps

module hdu_tb;

    localparam int DEPTH          = 8;
    localparam int id_w           = hdu_pkg::commit_id_w;
    localparam int ra_w           = hdu_pkg::reg_addr_w;
    localparam int RANDOM_CYCLES  = 1000;
    localparam int TIMEOUT_CYCLES = 2000; // about twice directed plus random
    localparam hdu_pkg::exu_type_t op_mul = hdu_pkg::exu_mul;
    localparam hdu_pkg::exu_type_t op_fpu = hdu_pkg::exu_fpu;

    logic clk;
    logic rst_n;
    logic inst_valid_i, rd_we_i, rs1_re_i, rs2_re_i, rs3_re_i;
    logic [ra_w-1:0] rd_addr_i, rs1_addr_i, rs2_addr_i, rs3_addr_i;
    hdu_pkg::exu_type_t exu_type_i;
    logic commit_valid_int_i, commit_valid_fp_i;
    logic [id_w-1:0] commit_id_int_i, commit_id_fp_i;
    logic hazard_stall_o, long_inst_atom_lock_o;
    logic [id_w-1:0] commit_id_o;

    // scoreboard model, state as it will be after the coming edge
    logic [DEPTH-1:0]   m_valid = '0;
    logic [ra_w-1:0]    m_rd [DEPTH];
    hdu_pkg::exu_type_t m_exu [DEPTH];
    logic [id_w:0]      pred;               // {stall, id}
    logic               stall_seen = 1'b0;  // upstream holds the request while set
    int n_checks  = 0;
    int n_errors  = 0;
    int cycle_cnt = 0;

    tb_clock_gen u_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

    hdu_top #(.DEPTH(DEPTH)) UUT (.*);

    // expected stall and id for the inputs of this cycle
    function automatic logic [id_w:0] predict();
        logic hazard;
        logic live;
        logic found;
        logic [id_w-1:0] free_id;
        hazard  = 1'b0;
        found   = 1'b0;
        free_id = '0;
        for (int k = 0; k < DEPTH; k++) begin
            live = m_valid[k] && !(commit_valid_int_i && commit_id_int_i == id_w'(k))
                              && !(commit_valid_fp_i && commit_id_fp_i == id_w'(k));
            if (live && inst_valid_i) begin
                if ((rs1_re_i && rs1_addr_i == m_rd[k]) || (rs2_re_i && rs2_addr_i == m_rd[k]) ||
                    (rs3_re_i && rs3_addr_i == m_rd[k]))
                    hazard = 1'b1; // raw
                if (rd_we_i && rd_addr_i == m_rd[k] && exu_type_i != m_exu[k])
                    hazard = 1'b1; // waw across units
            end
            if (!m_valid[k] && !found) begin
                free_id = id_w'(k);
                found   = 1'b1;
            end
        end
        if (&m_valid) hazard = 1'b1; // full, a commit this cycle does not help
        if (hazard || !(inst_valid_i && rd_we_i)) free_id = '0;
        return {hazard, free_id};
    endfunction

    task automatic advance(input logic stall);
        logic done;
        done = 1'b0;
        for (int k = 0; k < DEPTH; k++) begin
            if (inst_valid_i && rd_we_i && !stall && !m_valid[k] && !done) begin
                m_valid[k] = 1'b1;
                m_rd[k]    = rd_addr_i;
                m_exu[k]   = exu_type_i;
                done       = 1'b1;
            end
        end
        if (commit_valid_int_i) m_valid[commit_id_int_i] = 1'b0;
        if (commit_valid_fp_i)  m_valid[commit_id_fp_i]  = 1'b0;
    endtask

    function automatic logic [id_w-1:0] pick_pending();
        int idx [$];
        for (int k = 0; k < DEPTH; k++)
            if (m_valid[k]) idx.push_back(k);
        return id_w'(idx[$urandom % idx.size()]);
    endfunction

    task automatic step(input logic v, input logic we, input logic [ra_w-1:0] rd,
                        input hdu_pkg::exu_type_t exu, input logic [ra_w-1:0] a1,
                        input logic [ra_w-1:0] a2, input logic [ra_w-1:0] a3,
                        input logic [2:0] re, input logic ci, input logic [id_w-1:0] ii,
                        input logic cf, input logic [id_w-1:0] fi);
        @(posedge clk);
        inst_valid_i <= v;
        rd_we_i      <= we;
        rd_addr_i    <= rd;
        exu_type_i   <= exu;
        rs1_addr_i   <= a1;
        rs2_addr_i   <= a2;
        rs3_addr_i   <= a3;
        {rs3_re_i, rs2_re_i, rs1_re_i} <= re;
        commit_valid_int_i <= ci;
        commit_id_int_i    <= ii;
        commit_valid_fp_i  <= cf;
        commit_id_fp_i     <= fi;
    endtask

    task automatic random_cycle();
        @(posedge clk);
        if (!stall_seen) begin   // new request only once the last one went through
            inst_valid_i <= ($urandom % 10) < 8;
            rd_we_i      <= ($urandom % 10) < 7;
            rd_addr_i    <= ra_w'($urandom % 8); // narrow range for more conflicts
            rs1_addr_i   <= ra_w'($urandom % 8);
            rs2_addr_i   <= ra_w'($urandom % 8);
            rs3_addr_i   <= ra_w'($urandom % 8);
            {rs3_re_i, rs2_re_i, rs1_re_i} <= 3'($urandom);
            exu_type_i   <= hdu_pkg::exu_type_t'(2'($urandom % 3));
        end
        commit_valid_int_i <= (|m_valid) && ($urandom % 100) < 35;
        commit_id_int_i    <= (|m_valid) ? pick_pending() : id_w'($urandom);
        commit_valid_fp_i  <= (|m_valid) && ($urandom % 100) < 35;
        commit_id_fp_i     <= (|m_valid) ? pick_pending() : id_w'($urandom);
    endtask

    // compare mid-cycle, then move the model past the coming edge
    always @(negedge clk) begin
        if (!rst_n) begin
            m_valid = '0;
        end else begin
            pred = predict();
            n_checks++;
            if (hazard_stall_o !== pred[id_w]) begin
                $display("Mismatch hazard_stall_o: got %h expected %h at cycle %0d",
                         hazard_stall_o, pred[id_w], cycle_cnt);
                n_errors++;
            end
            if (commit_id_o !== pred[id_w-1:0]) begin
                $display("Mismatch commit_id_o: got %h expected %h at cycle %0d",
                         commit_id_o, pred[id_w-1:0], cycle_cnt);
                n_errors++;
            end
            if (long_inst_atom_lock_o !== (|m_valid)) begin
                $display("Mismatch long_inst_atom_lock_o: got %h expected %h at cycle %0d",
                         long_inst_atom_lock_o, |m_valid, cycle_cnt);
                n_errors++;
            end
            stall_seen = pred[id_w];
            advance(pred[id_w]);
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h53e04fdf));
        inst_valid_i <= 1'b0;
        rd_we_i      <= 1'b0;
        rd_addr_i    <= '0;
        rs1_addr_i   <= '0;
        rs2_addr_i   <= '0;
        rs3_addr_i   <= '0;
        {rs3_re_i, rs2_re_i, rs1_re_i} <= 3'b000;
        exu_type_i   <= op_mul;
        commit_valid_int_i <= 1'b0;
        commit_id_int_i    <= '0;
        commit_valid_fp_i  <= 1'b0;
        commit_id_fp_i     <= '0;
        wait (rst_n === 1'b1);
        for (int k = 0; k < DEPTH; k++)       // ids 0..7 in order, rd 1..8
            step(1, 1, ra_w'(k + 1), op_mul, 0, 0, 0, 3'b000, 0, 0, 0, 0);
        step(1, 1, 20, op_mul, 0, 0, 0, 3'b000, 0, 0, 0, 0); // full
        step(1, 1, 20, op_mul, 0, 0, 0, 3'b000, 1, 3, 0, 0); // full even while 3 retires
        step(1, 1, 20, op_mul, 0, 0, 0, 3'b000, 0, 0, 0, 0); // gets id 3
        step(0, 0, 0, op_mul, 0, 0, 0, 3'b000, 1, 5, 1, 6);
        step(1, 0, 0, op_mul, 1, 0, 0, 3'b001, 0, 0, 0, 0);  // raw on rs1
        step(1, 0, 0, op_mul, 0, 2, 0, 3'b010, 0, 0, 0, 0);  // raw on rs2
        step(1, 0, 0, op_mul, 0, 0, 20, 3'b100, 0, 0, 0, 0); // raw on rs3
        step(1, 1, 21, op_mul, 1, 2, 20, 3'b000, 0, 0, 0, 0); // sources off, id 5
        step(1, 1, 2, op_fpu, 0, 0, 0, 3'b000, 0, 0, 0, 0);  // waw, other unit
        step(1, 1, 2, op_mul, 0, 0, 0, 3'b000, 0, 0, 0, 0);  // same unit passes, id 6
        step(0, 0, 0, op_mul, 0, 0, 0, 3'b000, 1, 4, 1, 7);
        step(1, 1, 9, op_mul, 1, 0, 0, 3'b001, 1, 0, 0, 0);  // raw gone via int commit
        step(1, 1, 3, op_fpu, 0, 0, 0, 3'b000, 0, 0, 1, 2);  // waw gone via fp commit
        step(0, 0, 0, op_mul, 0, 0, 0, 3'b000, 1, 0, 1, 1);  // drain
        step(0, 0, 0, op_mul, 0, 0, 0, 3'b000, 1, 3, 1, 4);
        step(0, 0, 0, op_mul, 0, 0, 0, 3'b000, 1, 5, 1, 6);
        step(0, 0, 0, op_mul, 0, 0, 0, 3'b000, 0, 0, 0, 0);  // lock drops here
        repeat (RANDOM_CYCLES) random_cycle();
        step(0, 0, 0, op_mul, 0, 0, 0, 3'b000, 0, 0, 0, 0);
        repeat (2) @(posedge clk);
        $display("checks: %0d  mismatches: %0d  assertion failures: %0d",
                 n_checks, n_errors, UUT.u_hdu_assert.fail_count);
        if (n_errors == 0 && UUT.u_hdu_assert.fail_count == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// File: list.f
hdu_pkg.sv
hdu_slot_alloc.sv
hdu_track_entry.sv
hdu_hazard_merge.sv
hdu_top.sv
tb_clock_gen.sv
hdu_assert.sv
hdu_tb.sv

// File: run.sh
#!/bin/sh
# build hdu_tb with Verilator, run it, then look for the pass line in sim.log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f list.f --top-module hdu_tb -o hdu_sim \
    && ./obj_dir/hdu_sim | tee sim.log
grep -qx "Done: no errors" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
